// ==== Makefile ====
# Verilator flow for the crossbar testbench

OBJ = obj_dir
LOG = sim.log

.PHONY: all run lint clean

all: run

$(OBJ)/xbar_tb: build.f src/*.sv src/*.svh sim/*.sv
	verilator --binary --timing -sv -f build.f --top-module xbar_tb -Mdir $(OBJ) -o xbar_tb

# the log decides pass or fail
run: $(OBJ)/xbar_tb
	-./$(OBJ)/xbar_tb > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

lint:
	verilator --lint-only -sv +incdir+src src/xbar_pkg.sv src/channel_buffer.sv \
		src/bank_arbiter.sv src/bank_dispatch.sv src/xbar_core.sv --top-module xbar_core

clean:
	rm -rf $(OBJ) $(LOG)

// ==== build.f ====
+incdir+src
src/xbar_pkg.sv
src/channel_buffer.sv
src/bank_arbiter.sv
src/bank_dispatch.sv
src/xbar_core.sv
sim/xbar_tb.sv

// ==== sim/xbar_tb.sv ====
`timescale 1ns/100ps
`include "xbar_settings.svh"

module xbar_tb import xbar_pkg::*; ();

   localparam int NCH         = `XBAR_CHANNELS;
   localparam int NBANK       = `XBAR_BANKS;
   localparam int RUN_CYCLES  = 1500;   // mixed traffic
   localparam int FILL_CYCLES = 800;    // busy clients, slow ports
   localparam int DRAIN_LIMIT = 400;
   localparam int MAX_PASSED  = 2;      // round robin over three channels

   typedef logic [159:0] chk_t;   // holds any payload

   logic                     clk;
   logic                     rstn;
   logic      [NCH-1:0]      ch_valid;
   ch_req_t   [NCH-1:0]      ch_req;
   logic      [NCH-1:0]      ch_ready;
   logic      [NBANK-1:0]    htu_valid;
   htu_req_t  [NBANK-1:0]    htu_req;
   logic      [NBANK-1:0]    htu_ready;
   logic      [NBANK-1:0]    wbuf_valid;
   wbuf_req_t [NBANK-1:0]    wbuf_req;
   logic      [NBANK-1:0]    wbuf_ready;

   // reference model
   logic [31:0]              lcg_state = 32'd76;
   ch_req_t                  htu_exp   [NBANK][NCH][$];   // oldest first
   ch_req_t                  wbuf_exp  [NBANK][NCH][$];
   int                       outst     [NBANK][NCH];      // accepted, not finished
   int                       passed_by [NBANK][NCH];      // others served meanwhile
   logic [NBANK-1:0]         h_done;                      // port took current command
   logic [NBANK-1:0]         w_done;
   logic [`XBAR_CH_W-1:0]    h_ch [NBANK];
   logic [`XBAR_CH_W-1:0]    w_ch [NBANK];
   logic [NBANK-1:0]         h_stall_q;                   // valid without ready last cycle
   logic [NBANK-1:0]         w_stall_q;
   htu_req_t                 h_req_q [NBANK];
   wbuf_req_t                w_req_q [NBANK];

   xbar_core DUT (
      .clk        (clk),
      .rstn       (rstn),
      .ch_valid   (ch_valid),
      .ch_req     (ch_req),
      .ch_ready   (ch_ready),
      .htu_valid  (htu_valid),
      .htu_req    (htu_req),
      .htu_ready  (htu_ready),
      .wbuf_valid (wbuf_valid),
      .wbuf_req   (wbuf_req),
      .wbuf_ready (wbuf_ready)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 10 ns
   end

   ////////////////////////////////////////////////////////////////////////////
   // random source and error exits
   ////////////////////////////////////////////////////////////////////////////
   function automatic logic [15:0] rand16();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[31:16];   // low bits repeat too soon
   endfunction

   function automatic bit chance(input int pct);
      return (rand16() % 16'd100) < 16'(pct);
   endfunction

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_value(input string name, input chk_t got, input chk_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // stimulus, applied on the rising edge
   ////////////////////////////////////////////////////////////////////////////
   task automatic drive_inputs(input int valid_pct, input int ready_pct);
      logic      [NCH-1:0]     v;
      ch_req_t   [NCH-1:0]     rq;
      logic      [NBANK-1:0]   hr;
      logic      [NBANK-1:0]   wr;
      logic      [31:0]        a;
      logic      [15:0]        o;
      for (int c = 0; c < NCH; c++) begin
         a = {rand16(), rand16()};
         o = rand16();
         rq[c].op   = xbar_op_e'(o[1:0]);
         rq[c].addr = a[27:0];   // line address, bank in 9:8 of the byte address
         for (int i = 0; i < 8; i++) begin
            rq[c].data[i*16 +: 16] = rand16();
         end
         v[c] = chance(valid_pct);
      end
      for (int b = 0; b < NBANK; b++) begin
         hr[b] = chance(ready_pct);
         wr[b] = chance(ready_pct);
      end
      ch_valid   <= v;
      ch_req     <= rq;
      htu_ready  <= hr;
      wbuf_ready <= wr;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // scoreboards, sampled at the falling edge
   ////////////////////////////////////////////////////////////////////////////
   task automatic take_htu(input int b);
      ch_req_t     e;
      logic [31:0] byte_addr;
      int          c;
      c = int'(htu_req[b].ch);
      if (c >= NCH || htu_exp[b][c].size() == 0) begin
         stop_on_error($sformatf("bank %0d htu port sent a request that channel %0d never made",
                                 b, c));
      end
      e         = htu_exp[b][c].pop_front();   // oldest for this bank and channel
      byte_addr = {e.addr, 4'h0};              // line times 16
      check_value($sformatf("htu_req[%0d].op", b), chk_t'(htu_req[b].op), chk_t'(e.op));
      check_value($sformatf("htu_req[%0d].addr", b), chk_t'(htu_req[b].addr), chk_t'(byte_addr));
      check_value($sformatf("htu_req[%0d].set", b), chk_t'(htu_req[b].set),
                  chk_t'(byte_addr[7:5]));
      h_done[b] = 1'b1;
      h_ch[b]   = htu_req[b].ch;
   endtask

   task automatic take_wbuf(input int b);
      ch_req_t e;
      int      c;
      c = int'(wbuf_req[b].ch);
      if (c >= NCH || wbuf_exp[b][c].size() == 0) begin
         stop_on_error($sformatf("bank %0d wbuf port sent a request that channel %0d never made",
                                 b, c));
      end
      e = wbuf_exp[b][c].pop_front();
      check_value($sformatf("wbuf_req[%0d].data", b), chk_t'(wbuf_req[b].data), chk_t'(e.data));
      w_done[b] = 1'b1;
      w_ch[b]   = wbuf_req[b].ch;
   endtask

   // command done once both ports took it
   task automatic note_finish(input int b);
      int f;
      if (h_done[b] && w_done[b]) begin
         check_value($sformatf("wbuf_req[%0d].ch", b), chk_t'(w_ch[b]), chk_t'(h_ch[b]));
         f         = int'(h_ch[b]);
         h_done[b] = 1'b0;
         w_done[b] = 1'b0;
         outst[b][f]--;
         passed_by[b][f] = 0;
         for (int c = 0; c < NCH; c++) begin
            if (c != f && outst[b][c] > 0) begin
               passed_by[b][c]++;   // c kept waiting
               if (passed_by[b][c] > MAX_PASSED) begin
                  stop_on_error($sformatf("bank %0d served %0d other commands while channel %0d waited",
                                          b, passed_by[b][c], c));
               end
            end
         end
      end
   endtask

   task automatic monitor_cycle();
      logic [31:0] byte_addr;
      int          bank;
      int          total;
      for (int b = 0; b < NBANK; b++) begin   // held payload under back pressure
         if (h_stall_q[b]) begin
            check_value($sformatf("htu_valid[%0d]", b), chk_t'(htu_valid[b]), chk_t'(1'b1));
            check_value($sformatf("htu_req[%0d]", b), chk_t'(htu_req[b]), chk_t'(h_req_q[b]));
         end
         if (w_stall_q[b]) begin
            check_value($sformatf("wbuf_valid[%0d]", b), chk_t'(wbuf_valid[b]), chk_t'(1'b1));
            check_value($sformatf("wbuf_req[%0d]", b), chk_t'(wbuf_req[b]), chk_t'(w_req_q[b]));
         end
      end
      for (int b = 0; b < NBANK; b++) begin   // transfers at the coming edge
         if (htu_valid[b] && htu_ready[b]) take_htu(b);
         if (wbuf_valid[b] && wbuf_ready[b]) take_wbuf(b);
         note_finish(b);
      end
      for (int c = 0; c < NCH; c++) begin     // then new requests
         if (ch_valid[c] && ch_ready[c]) begin
            byte_addr = {ch_req[c].addr, 4'h0};
            bank      = int'(byte_addr[9:8]);
            htu_exp[bank][c].push_back(ch_req[c]);
            wbuf_exp[bank][c].push_back(ch_req[c]);
            outst[bank][c]++;
         end
         total = 0;
         for (int b = 0; b < NBANK; b++) begin
            total += outst[b][c];
         end
         if (total > `XBAR_DEPTH) begin
            stop_on_error($sformatf("channel %0d has %0d requests in flight, more than its buffer",
                                    c, total));
         end
      end
      for (int b = 0; b < NBANK; b++) begin
         h_stall_q[b] = htu_valid[b] & ~htu_ready[b];
         w_stall_q[b] = wbuf_valid[b] & ~wbuf_ready[b];
         h_req_q[b]   = htu_req[b];
         w_req_q[b]   = wbuf_req[b];
      end
   endtask

   function automatic int pending_total();
      int n;
      n = 0;
      for (int b = 0; b < NBANK; b++) begin
         for (int c = 0; c < NCH; c++) begin
            n += htu_exp[b][c].size() + wbuf_exp[b][c].size();
         end
      end
      return n;
   endfunction

   task automatic run_cycle(input int valid_pct, input int ready_pct);
      @(posedge clk);
      drive_inputs(valid_pct, ready_pct);
      @(negedge clk);
      monitor_cycle();
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      int waited;
      rstn       <= 1'b0;
      ch_valid   <= '0;
      ch_req     <= '0;
      htu_ready  <= '0;
      wbuf_ready <= '0;
      h_done    = '0;
      w_done    = '0;
      h_stall_q = '0;
      w_stall_q = '0;
      repeat (2) @(posedge clk);
      rstn <= 1'b1;
      @(negedge clk);   // first cycle out of reset
      check_value("htu_valid", chk_t'(htu_valid), '0);
      check_value("wbuf_valid", chk_t'(wbuf_valid), '0);
      check_value("ch_ready", chk_t'(ch_ready), chk_t'({NCH{1'b1}}));
      for (int i = 0; i < RUN_CYCLES; i++) begin
         run_cycle(60, 70);
      end
      for (int i = 0; i < FILL_CYCLES; i++) begin
         run_cycle(85, 25);   // buffers fill up
      end
      waited = 0;
      while (pending_total() != 0) begin   // stimulus off, ports always ready
         if (waited == DRAIN_LIMIT) begin
            stop_on_error("requests still pending after the drain timeout");
         end
         run_cycle(0, 100);
         waited++;
      end
      waited = 0;
      while (ch_ready != {NCH{1'b1}}) begin
         if (waited == DRAIN_LIMIT) begin
            stop_on_error("channel buffers did not free their entries in time");
         end
         run_cycle(0, 100);
         waited++;
      end
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

// ==== src/bank_arbiter.sv ====
`timescale 1ns/100ps
`include "xbar_settings.svh"

module bank_arbiter import xbar_pkg::*; (
   input  logic                              clk,
   input  logic                              rstn,
   input  bank_cand_t [`XBAR_CHANNELS-1:0]   cand,       // one per channel
   input  logic                              issue,      // command finished
   input  logic                              hold,       // one port already took it
   output logic                              cmd_valid,
   output bank_cmd_t                         cmd,
   output logic       [`XBAR_CHANNELS-1:0]   take
);

   localparam int NCH = `XBAR_CHANNELS;
   localparam int CW  = `XBAR_CH_W;
   localparam int CW1 = CW + 1;

   logic [NCH-1:0]     req;
   logic [CW-1:0]      last_q;    // channel of last grant
   logic [CW-1:0]      sel_q;     // choice shown last cycle
   logic               busy_q;    // that choice still unfinished
   logic [CW-1:0]      rr_pick;
   logic               rr_hit;
   logic               keep;
   logic [CW-1:0]      sel;

   always_comb begin
      for (int c = 0; c < NCH; c++) begin
         req[c] = cand[c].valid;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // round robin, starting after the last grant
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      logic [CW1-1:0] c;
      rr_hit  = 1'b0;
      rr_pick = last_q;
      for (int i = 1; i <= NCH; i++) begin   // last grant itself comes last
         c = {1'b0, last_q} + CW1'(i);
         if (c >= CW1'(NCH)) c = c - CW1'(NCH);   // wrap
         if (!rr_hit && req[c[CW-1:0]]) begin
            rr_hit  = 1'b1;
            rr_pick = c[CW-1:0];
         end
      end
   end

   // stalled or half sent command keeps its channel
   assign keep = hold | busy_q;
   assign sel  = keep ? sel_q : rr_pick;

   assign cmd_valid = req[sel];
   assign cmd.ch    = sel;
   assign cmd.req   = cand[sel].req;

   always_comb begin
      for (int c = 0; c < NCH; c++) begin
         take[c] = issue && (sel == CW'(c));   // clear winner's valid bit
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         last_q <= CW'(NCH - 1);   // channel 0 wins first
         sel_q  <= '0;
         busy_q <= 1'b0;
      end else begin
         sel_q  <= sel;
         busy_q <= cmd_valid & ~issue;
         if (issue) last_q <= sel;
      end
   end

endmodule

// ==== src/bank_dispatch.sv ====
`timescale 1ns/100ps
`include "xbar_settings.svh"

module bank_dispatch import xbar_pkg::*; (
   input  logic        clk,
   input  logic        rstn,
   input  logic        cmd_valid,
   input  bank_cmd_t   cmd,
   output logic        htu_valid,
   output htu_req_t    htu_req,
   input  logic        htu_ready,
   output logic        wbuf_valid,
   output wbuf_req_t   wbuf_req,
   input  logic        wbuf_ready,
   output logic        issue,        // both ports done this cycle
   output logic        hold          // exactly one port done
);

   logic htu_sent;    // htu took current command
   logic wbuf_sent;   // wbuf took current command
   logic htu_fire;
   logic wbuf_fire;
   logic htu_stall;
   logic wbuf_stall;

   ////////////////////////////////////////////////////////////////////////////
   // port handshakes
   ////////////////////////////////////////////////////////////////////////////
   assign htu_valid  = cmd_valid & ~htu_sent;
   assign wbuf_valid = cmd_valid & ~wbuf_sent;

   assign htu_fire   = htu_valid & htu_ready;
   assign wbuf_fire  = wbuf_valid & wbuf_ready;
   assign htu_stall  = htu_valid & ~htu_ready;     // still waiting on htu
   assign wbuf_stall = wbuf_valid & ~wbuf_ready;

   assign issue = cmd_valid & ~htu_stall & ~wbuf_stall;
   assign hold  = htu_sent | wbuf_sent;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         htu_sent  <= 1'b0;
         wbuf_sent <= 1'b0;
      end else if (issue) begin   // next command starts fresh
         htu_sent  <= 1'b0;
         wbuf_sent <= 1'b0;
      end else begin
         if (htu_fire)  htu_sent  <= 1'b1;
         if (wbuf_fire) wbuf_sent <= 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // payloads
   ////////////////////////////////////////////////////////////////////////////
   assign htu_req.ch   = cmd.ch;
   assign htu_req.op   = cmd.req.op;
   assign htu_req.addr = {cmd.req.addr, {`XBAR_ADDR_LSB{1'b0}}};   // line to byte
   assign htu_req.set  = cmd.req.addr[`XBAR_SET_LSB +: `XBAR_SET_W];   // addr 7:5

   assign wbuf_req.ch   = cmd.ch;
   assign wbuf_req.data = cmd.req.data;

endmodule

// ==== src/channel_buffer.sv ====
`timescale 1ns/100ps
`include "xbar_settings.svh"

module channel_buffer import xbar_pkg::*; (
   input  logic                             clk,
   input  logic                             rstn,
   input  logic                             ch_valid,
   input  ch_req_t                          ch_req,
   output logic                             ch_ready,
   input  logic       [`XBAR_BANKS-1:0]     take,   // one per bank
   output bank_cand_t [`XBAR_BANKS-1:0]     cand    // one per bank
);

   localparam int DEPTH = `XBAR_DEPTH;
   localparam int NBANK = `XBAR_BANKS;
   localparam int PW    = `XBAR_PTR_W;

   ch_req_t                          mem [DEPTH];   // payload only
   logic [NBANK-1:0][DEPTH-1:0]      vld;           // entry still owed to bank
   logic [PW-1:0]                    wptr;
   logic [PW-1:0]                    rptr;          // oldest unfreed entry
   logic [PW-1:0]                    count;
   logic                             push;
   logic                             pop;
   logic [`XBAR_BANK_W-1:0]          push_bank;
   logic [NBANK-1:0]                 head_busy;
   logic [NBANK-1:0]                 old_hit;
   logic [NBANK-1:0][PW-1:0]         old_idx;

   // circular increment over five slots
   function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
      return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // fill side
   ////////////////////////////////////////////////////////////////////////////
   assign ch_ready  = (count != PW'(DEPTH));   // full at five
   assign push      = ch_valid & ch_ready;
   assign push_bank = ch_req.addr[`XBAR_BANK_LSB +: `XBAR_BANK_W];   // addr 9:8

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wptr] <= ch_req;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // oldest entry per bank, searched up from the read pointer
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      logic [PW-1:0] p;
      for (int b = 0; b < NBANK; b++) begin
         old_hit[b] = 1'b0;
         old_idx[b] = '0;
         p          = rptr;
         for (int k = 0; k < DEPTH; k++) begin
            if (!old_hit[b] && vld[b][p]) begin   // first hit is oldest
               old_hit[b] = 1'b1;
               old_idx[b] = p;
            end
            p = ptr_inc(p);
         end
      end
   end

   always_comb begin
      for (int b = 0; b < NBANK; b++) begin
         cand[b].valid = old_hit[b];
         cand[b].idx   = old_idx[b];
         cand[b].req   = mem[old_idx[b]];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // retirement, in order
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      for (int b = 0; b < NBANK; b++) begin
         head_busy[b] = vld[b][rptr];   // this channel's own bits
      end
   end

   assign pop = (count != '0) && (head_busy == '0);   // head sent on both ports

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end else begin
         if (push) wptr <= ptr_inc(wptr);
         if (pop)  rptr <= ptr_inc(rptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
      end
   end

   // per bank valid bits, take clears, push sets
   always_ff @(posedge clk) begin
      if (!rstn) begin
         vld <= '0;
      end else begin
         for (int b = 0; b < NBANK; b++) begin
            if (take[b]) vld[b][old_idx[b]] <= 1'b0;
         end
         if (push) vld[push_bank][wptr] <= 1'b1;   // slot is free, no clash
      end
   end

endmodule

// ==== src/xbar_core.sv ====
`timescale 1ns/100ps
`include "xbar_settings.svh"

module xbar_core import xbar_pkg::*; (
   input  logic                                clk,
   input  logic                                rstn,
   // client channels
   input  logic       [`XBAR_CHANNELS-1:0]     ch_valid,
   input  ch_req_t    [`XBAR_CHANNELS-1:0]     ch_req,
   output logic       [`XBAR_CHANNELS-1:0]     ch_ready,
   // hit-test ports
   output logic       [`XBAR_BANKS-1:0]        htu_valid,
   output htu_req_t   [`XBAR_BANKS-1:0]        htu_req,
   input  logic       [`XBAR_BANKS-1:0]        htu_ready,
   // write-buffer ports
   output logic       [`XBAR_BANKS-1:0]        wbuf_valid,
   output wbuf_req_t  [`XBAR_BANKS-1:0]        wbuf_req,
   input  logic       [`XBAR_BANKS-1:0]        wbuf_ready
);

   localparam int NCH   = `XBAR_CHANNELS;
   localparam int NBANK = `XBAR_BANKS;

   bank_cand_t [NCH-1:0][NBANK-1:0]   cand_by_ch;     // channel major
   bank_cand_t [NBANK-1:0][NCH-1:0]   cand_by_bank;   // bank major
   logic       [NBANK-1:0][NCH-1:0]   take_by_bank;
   logic       [NCH-1:0][NBANK-1:0]   take_by_ch;
   logic       [NBANK-1:0]            cmd_valid;
   bank_cmd_t  [NBANK-1:0]            cmd;
   logic       [NBANK-1:0]            issue;
   logic       [NBANK-1:0]            hold;

   ////////////////////////////////////////////////////////////////////////////
   // channel side
   ////////////////////////////////////////////////////////////////////////////
   for (genvar c = 0; c < NCH; c++) begin : g_ch
      channel_buffer u_buf (
         .clk      (clk),
         .rstn     (rstn),
         .ch_valid (ch_valid[c]),
         .ch_req   (ch_req[c]),
         .ch_ready (ch_ready[c]),
         .take     (take_by_ch[c]),
         .cand     (cand_by_ch[c])
      );
   end

   // transpose channel x bank
   for (genvar c = 0; c < NCH; c++) begin : g_xc
      for (genvar b = 0; b < NBANK; b++) begin : g_xb
         assign cand_by_bank[b][c] = cand_by_ch[c][b];
         assign take_by_ch[c][b]   = take_by_bank[b][c];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // bank side, arbiter then dispatch
   ////////////////////////////////////////////////////////////////////////////
   for (genvar b = 0; b < NBANK; b++) begin : g_bank
      bank_arbiter u_arb (
         .clk       (clk),
         .rstn      (rstn),
         .cand      (cand_by_bank[b]),
         .issue     (issue[b]),
         .hold      (hold[b]),
         .cmd_valid (cmd_valid[b]),
         .cmd       (cmd[b]),
         .take      (take_by_bank[b])
      );

      bank_dispatch u_disp (
         .clk        (clk),
         .rstn       (rstn),
         .cmd_valid  (cmd_valid[b]),
         .cmd        (cmd[b]),
         .htu_valid  (htu_valid[b]),
         .htu_req    (htu_req[b]),
         .htu_ready  (htu_ready[b]),
         .wbuf_valid (wbuf_valid[b]),
         .wbuf_req   (wbuf_req[b]),
         .wbuf_ready (wbuf_ready[b]),
         .issue      (issue[b]),
         .hold       (hold[b])
      );
   end

endmodule

// ==== src/xbar_pkg.sv ====
`include "xbar_settings.svh"

package xbar_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // request opcodes
   ////////////////////////////////////////////////////////////////////////////
   typedef enum logic [`XBAR_OP_W-1:0] {
      op_read       = 2'd0,
      op_write      = 2'd1,
      op_flush      = 2'd2,
      op_invalidate = 2'd3
   } xbar_op_e;

   // client request, line address only
   typedef struct packed {
      xbar_op_e                                  op;
      logic [`XBAR_ADDR_W-1:`XBAR_ADDR_LSB]      addr;
      logic [`XBAR_DATA_W-1:0]                   data;
   } ch_req_t;

   // one channel's oldest entry for one bank
   typedef struct packed {
      logic                                      valid;
      logic [`XBAR_PTR_W-1:0]                    idx;   // entry slot
      ch_req_t                                   req;
   } bank_cand_t;

   // winner of a bank's arbitration
   typedef struct packed {
      logic [`XBAR_CH_W-1:0]                     ch;
      ch_req_t                                   req;
   } bank_cmd_t;

   ////////////////////////////////////////////////////////////////////////////
   // downstream payloads
   ////////////////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic [`XBAR_CH_W-1:0]                     ch;
      xbar_op_e                                  op;
      logic [`XBAR_ADDR_W-1:0]                   addr;  // byte address
      logic [`XBAR_SET_W-1:0]                    set;
   } htu_req_t;

   typedef struct packed {
      logic [`XBAR_CH_W-1:0]                     ch;
      logic [`XBAR_DATA_W-1:0]                   data;
   } wbuf_req_t;

endpackage

// ==== src/xbar_settings.svh ====
`ifndef XBAR_SETTINGS_SVH
`define XBAR_SETTINGS_SVH

// crossbar sizing
`define XBAR_CHANNELS 3          // client channels
`define XBAR_BANKS    4          // cache banks
`define XBAR_DEPTH    5          // entries per channel buffer

// field widths
`define XBAR_CH_W     2          // channel id
`define XBAR_BANK_W   2          // bank select
`define XBAR_PTR_W    3          // entry index, pointers and count
`define XBAR_OP_W     2
`define XBAR_ADDR_W   32         // byte address on the hit-test port
`define XBAR_DATA_W   128
`define XBAR_SET_W    3

// address bit positions
`define XBAR_ADDR_LSB 4          // 16 byte lines
`define XBAR_BANK_LSB 8          // bank is addr 9:8
`define XBAR_SET_LSB  5          // set is addr 7:5

`endif
